//--- shadow_capture.f
+incdir+logic
logic/shadow_bus_pkg.sv
logic/shadow_dump_pkg.sv
logic/shadow_bus_if.sv
logic/shadow_ram16.sv
logic/shadow_write_decode.sv
logic/shadow_readout.sv
logic/shadow_capture.sv
sim/shadow_capture_assert.sv
sim/shadow_capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the shadow memory testbench with Verilator, once per vram width
set -e
cd "$(dirname "$0")"

run_build() {
    local aw="$1"
    local mdir="obj_dir_aw${aw}"
    verilator --binary --timing --assert --x-initial 0 \
        -f shadow_capture.f --top-module shadow_capture_tb \
        -Gvram_aw="${aw}" -Mdir "${mdir}"
    if "./${mdir}/Vshadow_capture_tb" +verilator+error+limit+100 \
        | tee /dev/stderr | grep -Fx '*** PASSED ***' > /dev/null; then
        echo "vram_aw ${aw}: pass"
    else
        echo "vram_aw ${aw}: fail"
        exit 1
    fi
}

run_build 14
run_build 15

//--- sim/shadow_trace.txt
# W map region word_addr data dswn | T map tile_bank | R map dump_addr expected_byte test
# map 0 runs in both builds, 14 or 15 only in that vram build; numbers hex, dswn binary
W 0 vram 0000 1234 00
W 0 vram 3fff abcd 00
W 0 char 0000 5a3c 00
W 0 char 07ff c3e1 00
W 0 pal 0000 0f1e 00
W 0 pal 07ff 2d4b 00
W 0 obj 0000 6978 00
W 0 obj 03ff 8796 00
W 0 vram 0100 1111 00
W 0 vram 0100 aa22 01
W 0 pal 0020 3344 00
W 0 pal 0020 bbcc 10
T 0 2d
R 0 00000 12 full_word
R 0 00001 34 full_word
R 14 08001 3c full_word
R 15 10001 3c full_word
R 14 09000 0f full_word
R 15 11000 0f full_word
R 14 0a001 78 full_word
R 15 12001 78 full_word
R 0 00200 aa byte_mask
R 0 00201 11 byte_mask
R 14 09040 33 byte_mask
R 14 09041 cc byte_mask
R 15 11040 33 byte_mask
R 15 11041 cc byte_mask
R 0 07fff cd region_decode
R 14 08ffe c3 region_decode
R 15 10ffe c3 region_decode
R 14 09fff 4b region_decode
R 15 11fff 4b region_decode
R 14 0a7fe 87 region_decode
R 15 127fe 87 region_decode
R 14 0a800 ff region_decode
R 15 13000 ff region_decode
R 14 10000 12 region_decode
R 15 12800 00 tile_bank
R 15 12fff 2d tile_bank
T 0 13
R 15 12801 13 tile_bank
R 15 08000 00 upper_vram
R 15 0ffff 00 upper_vram

//--- sim/shadow_capture_tb.sv
// testbench for the shadow memory block that replays sim/shadow_trace.txt with random rsp_ready
`timescale 1ns/1ns

module shadow_capture_tb #(
    parameter int vram_aw = 14      // 15 picks the map with the tile bank word
);
    import shadow_bus_pkg::*;
    import shadow_dump_pkg::*;

    localparam int wait_limit = 64;  // cycles allowed per wait loop

    logic       clk_rom;
    logic       reset;
    cpu_addr_t  addr;
    word_t      din;
    logic [1:0] dswn;
    logic       vram_cs, char_cs, pal_cs, objram_cs;
    logic [5:0] tile_bank;
    logic       req_valid;
    logic       req_ready;
    dump_addr_t req_addr;
    logic       rsp_valid;
    logic       rsp_ready;
    dump_byte_t rsp_data;

    int    errors;        // whole run
    int    reads;
    bit    aborted;       // a wait ran out or the trace is broken
    int    test_errs;     // running test only
    int    test_reads;
    string cur_test;

    shadow_capture #(.vram_aw(vram_aw)) u_dut (.*);

    initial begin
        clk_rom = 1'b0;
        forever #2 clk_rom = ~clk_rom;  // 4 ns
    end

    task automatic count_error();
        test_errs++;
        errors++;
    endtask

    // closing line of the running test
    task automatic finish_test();
        if (cur_test != "") begin
            $display("test %s: %0d reads, %0d errors, %s", cur_test, test_reads, test_errs,
                     (test_errs == 0) ? "ok" : "failed");
        end
        cur_test   = "";
        test_reads = 0;
        test_errs  = 0;
    endtask

    // single cycle write through one chip select
    task automatic cpu_write(input string region, input cpu_addr_t a, input word_t d,
                             input logic [1:0] strobes);
        @(negedge clk_rom);
        addr      = a;
        din       = d;
        dswn      = strobes;
        vram_cs   = (region == "vram");
        char_cs   = (region == "char");
        pal_cs    = (region == "pal");
        objram_cs = (region == "obj");
        if (!(vram_cs || char_cs || pal_cs || objram_cs)) begin
            $display("trace names an unknown region %s", region);
            count_error();
        end
        @(negedge clk_rom);
        {vram_cs, char_cs, pal_cs, objram_cs} = 4'b0000;
        dswn = 2'b11;  // strobes idle high
    endtask

    // one dump request with latency, value and hold checks until the byte is taken
    task automatic dump_read(input dump_addr_t a, input dump_byte_t expected);
        int         waited;
        int         lat;
        dump_byte_t held;
        @(negedge clk_rom);
        req_valid = 1'b1;
        req_addr  = a;
        waited    = 0;
        while (!req_ready && waited < wait_limit) begin
            @(negedge clk_rom);
            waited++;
        end
        if (!req_ready) begin
            $display("timeout, req_ready stayed low for dump address %h", a);
            count_error();
            aborted = 1'b1;
            return;
        end
        lat = 0;  // handshake on the coming rising edge
        while (!rsp_valid && lat < wait_limit) begin
            @(negedge clk_rom);
            lat++;
            req_valid = 1'b0;
            rsp_ready = (($urandom % 3) == 0);  // ready one time in three for back-pressure
        end
        if (!rsp_valid) begin
            $display("timeout, no response for dump address %h", a);
            count_error();
            aborted = 1'b1;
            return;
        end
        reads++;
        test_reads++;
        assert (lat == 2) else begin
            $display("[ERROR] rsp_valid latency at %h is %0h cycles, expected %0h", a, lat, 2);
            count_error();
        end
        assert (rsp_data == expected) else begin
            $display("[ERROR] rsp_data at %h is %h, expected %h", a, rsp_data, expected);
            count_error();
        end
        held   = rsp_data;
        waited = 0;
        while (!rsp_ready && waited < wait_limit) begin  // byte must hold until taken
            @(negedge clk_rom);
            waited++;
            assert (rsp_valid) else begin
                $display("[ERROR] rsp_valid at %h is %h before the byte was taken, expected %h",
                         a, rsp_valid, 1'b1);
                count_error();
            end
            assert (rsp_data == held) else begin
                $display("[ERROR] rsp_data at %h moved to %h, held %h", a, rsp_data, held);
                count_error();
            end
            rsp_ready = (($urandom % 3) == 0);
        end
        if (!rsp_ready) begin
            $display("timeout, rsp_ready never drawn high for dump address %h", a);
            count_error();
            aborted = 1'b1;
            return;
        end
        @(negedge clk_rom);  // byte taken on the last rising edge
        rsp_ready = 1'b0;
        assert (!rsp_valid) else begin
            $display("[ERROR] rsp_valid at %h is %h after the byte was taken, expected %h",
                     a, rsp_valid, 1'b0);
            count_error();
        end
    endtask

    initial begin
        int         fd;
        int         n;
        int         map;
        string      kind;
        string      region;
        string      test_name;
        string      rest;
        cpu_addr_t  w_addr;
        word_t      w_data;
        logic [1:0] w_dswn;
        logic [5:0] t_val;
        dump_addr_t r_addr;
        dump_byte_t r_exp;

        void'($urandom(63921));  // one seed for the whole run
        reset     = 1'b1;
        addr      = '0;
        din       = '0;
        dswn      = 2'b11;
        {vram_cs, char_cs, pal_cs, objram_cs} = 4'b0000;
        tile_bank = '0;
        req_valid = 1'b0;
        req_addr  = '0;
        rsp_ready = 1'b0;
        errors    = 0;
        reads     = 0;
        aborted   = 1'b0;
        finish_test();
        repeat (2) @(posedge clk_rom);
        @(negedge clk_rom);
        reset = 1'b0;

        cur_test = "reset_state";  // idle with no request yet
        repeat (3) begin
            @(negedge clk_rom);
            assert (!rsp_valid) else begin
                $display("[ERROR] rsp_valid after reset is %h, expected %h", rsp_valid, 1'b0);
                count_error();
            end
            assert (req_ready) else begin
                $display("[ERROR] req_ready after reset is %h, expected %h", req_ready, 1'b1);
                count_error();
            end
        end
        finish_test();

        fd = $fopen("sim/shadow_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/shadow_trace.txt");
            errors++;
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, "%s", kind) == 1) begin
            if (kind.getc(0) == "#") begin
                n = $fgets(rest, fd);  // column notes
            end else if (kind == "W") begin
                n = $fscanf(fd, "%d %s %h %h %b", map, region, w_addr, w_data, w_dswn);
                if (n == 5 && (map == 0 || map == vram_aw)) begin
                    cpu_write(region, w_addr, w_data, w_dswn);
                end
            end else if (kind == "T") begin
                n = $fscanf(fd, "%d %h", map, t_val) + 3;
                if (n == 5 && (map == 0 || map == vram_aw)) begin
                    @(negedge clk_rom);
                    tile_bank = t_val;
                end
            end else if (kind == "R") begin
                n = $fscanf(fd, "%d %h %h %s", map, r_addr, r_exp, test_name) + 1;
                if (n == 5 && (map == 0 || map == vram_aw)) begin
                    if (test_name != cur_test) begin
                        finish_test();
                        cur_test = test_name;
                    end
                    dump_read(r_addr, r_exp);
                end
            end else begin
                n = 0;
            end
            if (n != 5 && kind.getc(0) != "#") begin
                $display("broken trace line starting with %s", kind);
                errors++;
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_test();

        $display("reads %0d, failed checks %0d, assertion failures %0d",
                 reads, errors, u_dut.u_assert.fail_count);
        if (errors == 0 && !aborted && u_dut.u_assert.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/shadow_capture_assert.sv
// handshake checks on the dump port, bound into shadow_capture for simulation only
`timescale 1ns/1ns

module shadow_capture_assert (
    input logic                        clk_rom,
    input logic                        reset,
    input logic                        req_valid,
    input logic                        req_ready,
    input logic                        rsp_valid,
    input logic                        rsp_ready,
    input shadow_dump_pkg::dump_byte_t rsp_data
);
    int unsigned fail_count = 0;   // summed up by the testbench at the end
    logic        handshake;

    assign handshake = req_valid && req_ready;

    // offered byte stays put until taken
    a_rsp_hold: assert property (@(posedge clk_rom) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
        else begin
            $error("rsp_valid or rsp_data moved before rsp_ready");
            fail_count++;
        end

    // address register edge, then ram edge
    a_latency: assert property (@(posedge clk_rom) disable iff (reset)
        $past(handshake, 2) |-> rsp_valid)
        else begin
            $error("rsp_valid missing two cycles after the request handshake");
            fail_count++;
        end

    a_no_early: assert property (@(posedge clk_rom) disable iff (reset)
        $rose(rsp_valid) |-> $past(handshake, 2))
        else begin
            $error("rsp_valid rose without a handshake two cycles before");
            fail_count++;
        end

    // busy from the handshake until the byte is accepted
    a_busy_read: assert property (@(posedge clk_rom) disable iff (reset)
        $past(handshake) |-> !req_ready)
        else begin
            $error("req_ready high while the ram read is in flight");
            fail_count++;
        end

    a_busy_hold: assert property (@(posedge clk_rom) disable iff (reset)
        rsp_valid |-> !req_ready)
        else begin
            $error("req_ready high while a response is pending");
            fail_count++;
        end

endmodule

bind shadow_capture shadow_capture_assert u_assert (
    .clk_rom   (clk_rom),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
);

//--- logic/shadow_capture.sv
// shadow memory top level: mirrors cpu video writes and reads them back bytewise for a dump
`timescale 1ns/1ns
`include "shadow_macros.svh"

module shadow_capture #(
    parameter int vram_aw = `SHADOW_VRAM_AW_DEFAULT     // 14 or 15
) (
    input  logic                         clk_rom,
    input  logic                         reset,
    // cpu write snoop
    input  shadow_bus_pkg::cpu_addr_t    addr,
    input  shadow_bus_pkg::word_t        din,
    input  logic [1:0]                   dswn,       // active low byte strobes
    input  logic                         vram_cs,
    input  logic                         char_cs,
    input  logic                         pal_cs,
    input  logic                         objram_cs,
    input  logic [5:0]                   tile_bank,
    // dump request
    input  logic                         req_valid,
    output logic                         req_ready,
    input  shadow_dump_pkg::dump_addr_t  req_addr,
    // dump response
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output shadow_dump_pkg::dump_byte_t  rsp_data
);
    import shadow_bus_pkg::*;

    byte_en_t                   vram_we, char_we, pal_we, obj_we;
    logic [vram_aw-1:0]         vram_waddr;
    logic [`SHADOW_CHAR_AW-1:0] char_waddr;
    logic [`SHADOW_PAL_AW-1:0]  pal_waddr;
    logic [`SHADOW_OBJ_AW-1:0]  obj_waddr;
    word_t                      wdata;
    word_t                      vram_q, char_q, pal_q, obj_q;
    logic [vram_aw-1:0]         rd_addr;    // shared read address, widest region

    shadow_bus_if u_bus ();

    // pins into the bundle
    assign u_bus.addr      = addr;
    assign u_bus.din       = din;
    assign u_bus.dswn      = dswn;
    assign u_bus.vram_cs   = vram_cs;
    assign u_bus.char_cs   = char_cs;
    assign u_bus.pal_cs    = pal_cs;
    assign u_bus.objram_cs = objram_cs;

    shadow_write_decode #(.vram_aw(vram_aw)) u_decode (
        .bus        (u_bus.sink),
        .vram_we    (vram_we),
        .char_we    (char_we),
        .pal_we     (pal_we),
        .obj_we     (obj_we),
        .vram_waddr (vram_waddr),
        .char_waddr (char_waddr),
        .pal_waddr  (pal_waddr),
        .obj_waddr  (obj_waddr),
        .wdata      (wdata)
    );

    // each ram reads the low bits of the shared address
    shadow_ram16 #(.aw(vram_aw)) u_vram (
        .clk_rom (clk_rom),
        .we      (vram_we),
        .waddr   (vram_waddr),
        .wdata   (wdata),
        .raddr   (rd_addr),
        .q       (vram_q)
    );

    shadow_ram16 #(.aw(`SHADOW_CHAR_AW)) u_char (
        .clk_rom (clk_rom),
        .we      (char_we),
        .waddr   (char_waddr),
        .wdata   (wdata),
        .raddr   (rd_addr[`SHADOW_CHAR_AW-1:0]),
        .q       (char_q)
    );

    shadow_ram16 #(.aw(`SHADOW_PAL_AW)) u_pal (
        .clk_rom (clk_rom),
        .we      (pal_we),
        .waddr   (pal_waddr),
        .wdata   (wdata),
        .raddr   (rd_addr[`SHADOW_PAL_AW-1:0]),
        .q       (pal_q)
    );

    shadow_ram16 #(.aw(`SHADOW_OBJ_AW)) u_objram (
        .clk_rom (clk_rom),
        .we      (obj_we),
        .waddr   (obj_waddr),
        .wdata   (wdata),
        .raddr   (rd_addr[`SHADOW_OBJ_AW-1:0]),
        .q       (obj_q)
    );

    shadow_readout #(.vram_aw(vram_aw)) u_readout (
        .clk_rom   (clk_rom),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .rd_addr   (rd_addr),
        .vram_q    (vram_q),
        .char_q    (char_q),
        .pal_q     (pal_q),
        .obj_q     (obj_q),
        .tile_bank (tile_bank),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

endmodule

//--- logic/shadow_readout.sv
// dump readout: takes one byte request at a time, reads the shadow rams and holds the byte
`timescale 1ns/1ns
`include "shadow_macros.svh"

module shadow_readout #(
    parameter int vram_aw = `SHADOW_VRAM_AW_DEFAULT     // selects the region map
) (
    input  logic                         clk_rom,
    input  logic                         reset,
    // request channel
    input  logic                         req_valid,
    output logic                         req_ready,
    input  shadow_dump_pkg::dump_addr_t  req_addr,
    // shared ram read port
    output logic [vram_aw-1:0]           rd_addr,
    input  shadow_bus_pkg::word_t        vram_q,
    input  shadow_bus_pkg::word_t        char_q,
    input  shadow_bus_pkg::word_t        pal_q,
    input  shadow_bus_pkg::word_t        obj_q,
    input  logic [5:0]                   tile_bank,
    // response channel
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output shadow_dump_pkg::dump_byte_t  rsp_data
);
    import shadow_bus_pkg::*;
    import shadow_dump_pkg::*;

    readout_state_e state;
    dump_addr_t     addr_q;     // accepted byte address
    logic           first;      // first hold cycle, byte still comes from the ram
    dump_byte_t     data_q;     // byte kept for the rest of the hold
    region_e        region;
    word_t          sel_word;
    dump_byte_t     sel_byte;

    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_hold);
    assign rd_addr   = addr_q[vram_aw:1];  // word address, wider than small rams

    // handshake edge -> st_read, ram edge -> st_hold, so rsp_valid is seen 2 edges later
    always_ff @(posedge clk_rom) begin
        if (reset) begin
            state <= st_idle;
            first <= 1'b0;
        end else begin
            unique case (state)
                st_idle: if (req_valid) state <= st_read;
                st_read: state <= st_hold;           // ram q lands on this edge
                st_hold: if (rsp_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
            first <= (state == st_read);  // high for the first hold cycle only
        end
    end

    always_ff @(posedge clk_rom) begin
        if (req_valid && req_ready) begin
            addr_q <= req_addr;
        end
        if (first) begin
            data_q <= sel_byte;  // freeze, later cpu writes must not leak in
        end
    end

    // region map, picked by the vram width
    always_comb begin
        region = rg_none;
        if (vram_aw == 14) begin
            casez (addr_q[15:11])    // bit 16 ignored, map mirrors
                5'b0????: region = rg_vram;  // 32kB
                5'b1000?: region = rg_char;  // 4kB
                5'b1001?: region = rg_pal;   // 4kB
                5'b10100: region = rg_obj;   // 2kB
                default:  region = rg_none;
            endcase
        end else if (!addr_q[16]) begin
            region = rg_vram;               // full 64kB
        end else begin
            case (addr_q[15:12])
                4'h0:    region = rg_char;
                4'h1:    region = rg_pal;
                4'h2:    region = addr_q[11] ? rg_tile : rg_obj;
                default: region = rg_none;
            endcase
        end
    end

    always_comb begin
        unique case (region)
            rg_vram: sel_word = vram_q;
            rg_char: sel_word = char_q;
            rg_pal:  sel_word = pal_q;
            rg_obj:  sel_word = obj_q;
            rg_tile: sel_word = {10'd0, tile_bank};  // readable bank register
            default: sel_word = `SHADOW_FILL;
        endcase
    end

    // big endian byte order, even address is the upper byte
    assign sel_byte = addr_q[0] ? sel_word[7:0] : sel_word[15:8];

    assign rsp_data = first ? sel_byte : data_q;

endmodule

//--- logic/shadow_write_decode.sv
// cpu write decode: chip selects and strobes to per region byte enables and address slices
`timescale 1ns/1ns
`include "shadow_macros.svh"

module shadow_write_decode #(
    parameter int vram_aw = `SHADOW_VRAM_AW_DEFAULT     // 14 or 15
) (
    shadow_bus_if.sink                     bus,
    // byte enables per region
    output shadow_bus_pkg::byte_en_t       vram_we,
    output shadow_bus_pkg::byte_en_t       char_we,
    output shadow_bus_pkg::byte_en_t       pal_we,
    output shadow_bus_pkg::byte_en_t       obj_we,
    // word addresses per region
    output logic [vram_aw-1:0]             vram_waddr,
    output logic [`SHADOW_CHAR_AW-1:0]     char_waddr,
    output logic [`SHADOW_PAL_AW-1:0]      pal_waddr,
    output logic [`SHADOW_OBJ_AW-1:0]      obj_waddr,
    // common write data
    output shadow_bus_pkg::word_t          wdata
);
    import shadow_bus_pkg::*;

    byte_en_t wr_mask;  // strobes flipped to active high

    assign wr_mask = ~bus.dswn;

    // a select with no strobe low writes nothing
    assign vram_we = bus.vram_cs   ? wr_mask : '0;
    assign char_we = bus.char_cs   ? wr_mask : '0;
    assign pal_we  = bus.pal_cs    ? wr_mask : '0;
    assign obj_we  = bus.objram_cs ? wr_mask : '0;

    // cpu only drives 14 word bits, the 15 bit vram gets a zero on top
    assign vram_waddr = vram_aw'(bus.addr);

    // small regions mirror across the upper cpu bits
    assign char_waddr = bus.addr[`SHADOW_CHAR_AW:1];
    assign pal_waddr  = bus.addr[`SHADOW_PAL_AW:1];
    assign obj_waddr  = bus.addr[`SHADOW_OBJ_AW:1];

    assign wdata = bus.din;  // same word goes to every ram

endmodule

//--- logic/shadow_ram16.sv
// dual port 16 bit shadow ram, byte masked write port and registered read port
`timescale 1ns/1ns

module shadow_ram16 #(
    parameter int aw = 10                   // word address width
) (
    input  logic                     clk_rom,
    // write port, fed by the cpu decode
    input  shadow_bus_pkg::byte_en_t we,    // per byte enable
    input  logic [aw-1:0]            waddr,
    input  shadow_bus_pkg::word_t    wdata,
    // read port, fed by the dump readout
    input  logic [aw-1:0]            raddr,
    output shadow_bus_pkg::word_t    q      // valid one cycle after raddr
);
    import shadow_bus_pkg::*;

    localparam int depth = 2 ** aw;

    word_t mem [depth];  // contents survive reset

    // byte lanes written separately
    always_ff @(posedge clk_rom) begin
        if (we[1]) begin
            mem[waddr][15:8] <= wdata[15:8];  // upper lane
        end
        if (we[0]) begin
            mem[waddr][7:0] <= wdata[7:0];  // lower lane
        end
    end

    // same address write and read in one cycle returns the old word
    always_ff @(posedge clk_rom) begin
        q <= mem[raddr];
    end

endmodule

//--- logic/shadow_bus_if.sv
// cpu write bundle, driven from the top level pins and read by the write decoder
`timescale 1ns/1ns

interface shadow_bus_if;
    import shadow_bus_pkg::*;

    cpu_addr_t  addr;       // word address, bits 14..1
    word_t      din;        // write data
    logic [1:0] dswn;       // byte strobes, active low, bit 1 is upper byte
    logic       vram_cs;    // chip selects, one per video memory
    logic       char_cs;
    logic       pal_cs;
    logic       objram_cs;

    // top level side
    modport src (
        output addr,
        output din,
        output dswn,
        output vram_cs,
        output char_cs,
        output pal_cs,
        output objram_cs
    );

    // decoder side
    modport sink (
        input addr,
        input din,
        input dswn,
        input vram_cs,
        input char_cs,
        input pal_cs,
        input objram_cs
    );

endinterface

//--- logic/shadow_dump_pkg.sv
// types for the dump side: byte address map, byte data, region tags and readout fsm states
package shadow_dump_pkg;

    // flat byte address into the dump map, bit 0 picks the byte
    typedef logic [16:0] dump_addr_t;

    // one byte handed back per request
    typedef logic [7:0] dump_byte_t;

    // where a dump address lands
    typedef enum logic [2:0] {
        rg_vram,    // video ram
        rg_char,    // character ram
        rg_pal,     // palette ram
        rg_obj,     // object ram
        rg_tile,    // tile bank register, 15 bit map only
        rg_none     // hole, reads as fill
    } region_e;

    // readout fsm
    typedef enum logic [1:0] {
        st_idle,    // waiting for a request
        st_read,    // address held, ram read in flight
        st_hold     // byte on rsp_data until taken
    } readout_state_e;

endpackage

//--- logic/shadow_bus_pkg.sv
// types for the cpu write side, shared by the bus interface, the decoder and the rams
package shadow_bus_pkg;

    // one video memory word as the cpu writes it
    typedef logic [15:0] word_t;

    // byte write enable after decode, active high
    // bit 1 -> high byte (d15..d8)
    // bit 0 -> low byte (d7..d0)
    typedef logic [1:0] byte_en_t;

    // cpu word address, kept with byte address numbering
    // so the slices match the board schematics: addr[11:1] etc.
    typedef logic [14:1] cpu_addr_t;

endpackage

//--- logic/shadow_macros.svh
// region widths and fill word for the shadow memory block, include wherever a region is sized
`ifndef SHADOW_MACROS_SVH
`define SHADOW_MACROS_SVH

// word address widths of the fixed size regions
`define SHADOW_CHAR_AW 11   // 2k words, 4kB char ram
`define SHADOW_PAL_AW 11    // 2k words, 4kB palette
`define SHADOW_OBJ_AW 10    // 1k words, 2kB object ram

// vram depth follows the board variant
// 14 -> 16k words, compact dump map
// 15 -> 32k words, dump map with tile bank word
`define SHADOW_VRAM_AW_DEFAULT 14

// word seen on the dump port for holes in the map
`define SHADOW_FILL 16'hffff

`endif
